// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  --top-module cache_tb -f src.f -o cache_sim
if [ $? -ne 0 ]; then
  echo "verilator build did not succeed"
  exit 1
fi

output=$(./obj_dir/cache_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== src.f ====
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_tag_array.sv
verilog/cache_data_array.sv
verilog/line_memory.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tb/cache_tb.sv

// ==== tb/cache_tb.sv ====
`include "cache_config.svh"

`default_nettype none

module cache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 16;
  localparam int NUM_DIRECTED = 14;
  localparam int NUM_RANDOM = 40;
  localparam int NUM_ENTRIES = NUM_DIRECTED + NUM_RANDOM;
  // worst case per entry is write-back plus refill plus handshake slack
  localparam int CYCLE_LIMIT =
    NUM_ENTRIES * (3 * (`CACHE_MEM_LATENCY + 2) + 4) + RESET_CYCLES;

  // byte address layout: tag | index | word offset | byte
  localparam int OFFSET_LSB = $clog2(`CACHE_WORD_W / 8);
  localparam int OFFSET_BITS = $clog2(`CACHE_LINE_WORDS);
  localparam int INDEX_LSB = OFFSET_LSB + OFFSET_BITS;
  localparam int INDEX_BITS = $clog2(`CACHE_NUM_SETS);
  localparam int TAG_LSB = INDEX_LSB + INDEX_BITS;
  // backing store as words, upper address bits wrap
  localparam int MEM_WORDS = `CACHE_MEM_LINES * `CACHE_LINE_WORDS;
  localparam int MEM_WORD_BITS = $clog2(MEM_WORDS);

  typedef struct packed {
    logic write;
    cache_pkg::addr_t addr;
    cache_pkg::word_t wdata;
  } stim_t;

  // write flag, address, data
  localparam stim_t DIRECTED [NUM_DIRECTED] = '{
    // cold read, then hits on the same line
    '{1'b0, 32'h0000_0010, 32'h0000_0000},
    '{1'b1, 32'h0000_0014, 32'hcafe_0001},
    '{1'b0, 32'h0000_0014, 32'h0000_0000},
    '{1'b0, 32'h0000_0010, 32'h0000_0000},
    '{1'b0, 32'h0000_001c, 32'h0000_0000},
    // set 2, tag 1 made dirty, then evicted by tag 2
    '{1'b1, 32'h0000_0120, 32'h1234_5678},
    '{1'b1, 32'h0000_0128, 32'h0bad_f00d},
    '{1'b0, 32'h0000_0220, 32'h0000_0000},
    '{1'b0, 32'h0000_0120, 32'h0000_0000},
    '{1'b0, 32'h0000_0128, 32'h0000_0000},
    '{1'b0, 32'h0000_0124, 32'h0000_0000},
    // write miss allocates, then a conflict pushes it out
    '{1'b1, 32'h0000_0f30, 32'h5a5a_a5a5},
    '{1'b0, 32'h0000_0030, 32'h0000_0000},
    '{1'b0, 32'h0000_0f30, 32'h0000_0000}
  };

  logic clk;
  logic reset;
  logic req_valid;
  cache_pkg::cache_req_t req;
  logic ready;
  logic resp_valid;
  cache_pkg::word_t rdata;
  logic hit;

  // high from acceptance until the cycle after the response
  logic pending = 1'b0;
  int cycle_count = 0;
  int error_count = 0;

  // reference model state
  cache_pkg::word_t shadow_mem [MEM_WORDS];
  cache_pkg::tag_t shadow_tag [`CACHE_NUM_SETS];
  logic shadow_valid [`CACHE_NUM_SETS];

  stim_t stim_q[$];

  cache_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .ready      (ready),
    .resp_valid (resp_valid),
    .rdata      (rdata),
    .hit        (hit)
  );

  always #10 clk = ~clk;

  task automatic stop_with_failure();
    error_count++;
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_word(input string name, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic cache_pkg::tag_t tag_of(input cache_pkg::addr_t a);
    return a[`CACHE_ADDR_W-1:TAG_LSB];
  endfunction

  function automatic cache_pkg::index_t index_of(input cache_pkg::addr_t a);
    return a[INDEX_LSB +: INDEX_BITS];
  endfunction

  // word slot in the backing store, line row and offset together
  function automatic logic [MEM_WORD_BITS-1:0] word_slot(input cache_pkg::addr_t a);
    return a[OFFSET_LSB +: MEM_WORD_BITS];
  endfunction

  // sets 4 to 7 and tags 1 to 3, so conflicts come often
  function automatic cache_pkg::addr_t conflict_addr(input logic [31:0] r);
    int t;
    int s;
    cache_pkg::addr_t a;
    t = 1 + int'(r[9:8]) % 3;
    s = 4 + int'(r[1:0]);
    a = cache_pkg::addr_t'(t) << TAG_LSB;
    a = a | (cache_pkg::addr_t'(s) << INDEX_LSB);
    a = a | (cache_pkg::addr_t'(r[3:2]) << OFFSET_LSB);
    return a;
  endfunction

  // one request through the whole handshake, entered just after a rising edge
  task automatic run_request(input stim_t s);
    cache_pkg::tag_t t;
    cache_pkg::index_t idx;
    logic exp_hit;
    cache_pkg::word_t exp_rdata;
    int cycles;
    logic seen;
    t = tag_of(s.addr);
    idx = index_of(s.addr);
    exp_hit = shadow_valid[idx] && (shadow_tag[idx] == t);
    exp_rdata = shadow_mem[word_slot(s.addr)];
    req_valid = 1'b1;
    req.addr = s.addr;
    req.write = s.write;
    req.wdata = s.wdata;
    @(negedge clk);
    while (!ready) @(negedge clk);
    // accepted on this edge
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    req = '0;
    pending = 1'b1;
    cycles = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      cycles++;
      // busy until the response cycle has passed
      compare_bit("ready", ready, 1'b0);
      if (resp_valid === 1'b1) begin
        seen = 1'b1;
      end
    end
    compare_bit("hit", hit, exp_hit);
    if (exp_hit) begin
      compare_bit("hit latency of one cycle", cycles == 1, 1'b1);
    end else begin
      compare_bit("miss latency above one cycle", cycles > 1, 1'b1);
    end
    if (!s.write) begin
      compare_word("rdata", rdata, exp_rdata);
    end
    // write-allocate, so the line is resident afterwards either way
    if (s.write) begin
      shadow_mem[word_slot(s.addr)] = s.wdata;
    end
    shadow_valid[idx] = 1'b1;
    shadow_tag[idx] = t;
    @(posedge clk);
    #2;
    pending = 1'b0;
  endtask

  // a response with nothing outstanding
  always @(negedge clk) begin
    if (!reset && resp_valid === 1'b1 && !pending) begin
      $display("resp_valid pulsed at %0t with no request pending", $time);
      stop_with_failure();
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_with_failure();
    end
  end

  initial begin
    logic [31:0] r;
    stim_t s;
    clk = 1'b0;
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    void'($urandom(32'h375b));
    // memory starts zeroed and every line invalid
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow_mem[i] = '0;
    end
    for (int i = 0; i < `CACHE_NUM_SETS; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i] = '0;
    end
    for (int i = 0; i < NUM_DIRECTED; i++) begin
      stim_q.push_back(DIRECTED[i]);
    end
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $urandom();
      s.write = r[16];
      s.addr = conflict_addr(r);
      s.wdata = $urandom();
      stim_q.push_back(s);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    compare_bit("ready", ready, 1'b1);
    compare_bit("resp_valid", resp_valid, 1'b0);
    @(posedge clk);
    #2;
    foreach (stim_q[i]) begin
      run_request(stim_q[i]);
    end
    if (error_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cache_config.svh ====
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte address and data word widths
`define CACHE_ADDR_W 32
`define CACHE_WORD_W 32

// cache geometry
// direct mapped, so one line per set
`define CACHE_LINE_WORDS 4
`define CACHE_NUM_SETS 16

// backing store size in lines
`define CACHE_MEM_LINES 256

// cycles between the memory taking a request and finishing it
`define CACHE_MEM_LATENCY 4

`endif

// ==== verilog/cache_ctrl.sv ====
`default_nettype none

module cache_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  input  cache_pkg::cache_req_t  req,
  output logic                   ready,
  output logic                   resp_valid,
  output cache_pkg::word_t       rdata,
  output logic                   hit,
  output cache_pkg::index_t      index,
  output cache_pkg::offset_t     offset,
  input  logic                   tag_hit,
  input  cache_pkg::tag_entry_t  victim,
  input  cache_pkg::line_t       line,
  input  cache_pkg::word_t       word,
  output logic                   tag_we,
  output cache_pkg::tag_entry_t  tag_wentry,
  output logic                   data_we,
  output cache_pkg::line_t       data_wline,
  output cache_pkg::word_t       data_wword,
  output logic                   data_merge,
  output logic                   mem_valid,
  output cache_pkg::mem_req_t    mem_req,
  input  logic                   mem_ready,
  input  logic                   mem_done,
  input  cache_pkg::line_t       mem_rline
);

  cache_pkg::ctrl_state_t state;
  cache_pkg::ctrl_state_t state_next;
  cache_pkg::cache_req_t req_q;
  // set by the first failed compare, held until the next request
  logic missed;
  cache_pkg::tag_t req_tag;
  cache_pkg::line_addr_t fill_addr;
  cache_pkg::line_addr_t victim_addr;

  // address fields of the latched request
  assign req_tag = req_q.addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
  assign index = req_q.addr[cache_pkg::BYTE_W + cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
  assign offset = req_q.addr[cache_pkg::BYTE_W +: cache_pkg::OFFSET_W];

  // line being fetched and line being evicted
  assign fill_addr = {req_tag, index};
  assign victim_addr = {victim.tag, index};

  assign ready = (state == cache_pkg::st_idle);
  assign rdata = word;

  // a refill stores the fetched line whole, a write hit merges one word
  assign data_wline = mem_rline;
  assign data_wword = req_q.wdata;

  always_comb begin
    state_next = state;
    resp_valid = 1'b0;
    hit = 1'b0;
    // written tag is always the request tag, clean unless a write hit
    tag_we = 1'b0;
    tag_wentry.tag = req_tag;
    tag_wentry.valid = 1'b1;
    tag_wentry.dirty = 1'b0;
    data_we = 1'b0;
    data_merge = 1'b0;
    // refill read by default
    mem_valid = 1'b0;
    mem_req.line_addr = fill_addr;
    mem_req.write = 1'b0;
    mem_req.wline = line;
    case (state)
      cache_pkg::st_idle: begin
        if (req_valid) begin
          state_next = cache_pkg::st_compare;
        end
      end
      cache_pkg::st_compare: begin
        if (tag_hit) begin
          resp_valid = 1'b1;
          // a hit after refill still reports the original miss
          hit = !missed;
          if (req_q.write) begin
            tag_we = 1'b1;
            tag_wentry.dirty = 1'b1;
            data_we = 1'b1;
            data_merge = 1'b1;
          end
          state_next = cache_pkg::st_idle;
        end else if (mem_ready) begin
          mem_valid = 1'b1;
          if (victim.valid && victim.dirty) begin
            // evict the old line before fetching
            mem_req.line_addr = victim_addr;
            mem_req.write = 1'b1;
            state_next = cache_pkg::st_write_back;
          end else begin
            state_next = cache_pkg::st_allocate;
          end
        end
      end
      cache_pkg::st_write_back: begin
        // memory is idle again in its done cycle, start the refill there
        if (mem_done && mem_ready) begin
          mem_valid = 1'b1;
          state_next = cache_pkg::st_allocate;
        end
      end
      cache_pkg::st_allocate: begin
        if (mem_done) begin
          data_we = 1'b1;
          tag_we = 1'b1;
          state_next = cache_pkg::st_compare;
        end
      end
      default: begin
        state_next = cache_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::st_idle;
      missed <= 1'b0;
    end else begin
      state <= state_next;
      if (ready && req_valid) begin
        missed <= 1'b0;
      end else if (state == cache_pkg::st_compare && !tag_hit) begin
        missed <= 1'b1;
      end
    end
  end

  // request held for the whole transaction
  always_ff @(posedge clk) begin
    if (ready && req_valid) begin
      req_q <= req;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cache_data_array.sv ====
`include "cache_config.svh"

`default_nettype none

module cache_data_array (
  input  logic                clk,
  input  cache_pkg::index_t   index,
  input  cache_pkg::offset_t  offset,
  input  logic                we,
  input  logic                merge,
  input  cache_pkg::line_t    wline,
  input  cache_pkg::word_t    wword,
  output cache_pkg::line_t    line,
  output cache_pkg::word_t    word
);

  // one line per set
  cache_pkg::line_t lines [`CACHE_NUM_SETS];

  // whole line goes to write-back, selected word to the client
  assign line = lines[index];
  assign word = line[offset];

  always_ff @(posedge clk) begin
    if (we) begin
      if (merge) begin
        // write hit touches only the addressed word
        lines[index][offset] <= wword;
      end else begin
        // refill
        lines[index] <= wline;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
`include "cache_config.svh"

`default_nettype none

package cache_pkg;

  // field widths derived from the geometry
  localparam int ADDR_W = `CACHE_ADDR_W;
  localparam int WORD_W = `CACHE_WORD_W;
  localparam int BYTE_W = $clog2(`CACHE_WORD_W / 8);
  localparam int OFFSET_W = $clog2(`CACHE_LINE_WORDS);
  localparam int INDEX_W = $clog2(`CACHE_NUM_SETS);
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;
  localparam int LINE_ADDR_W = TAG_W + INDEX_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  // word 0 sits in the low bits of the line
  typedef logic [`CACHE_LINE_WORDS-1:0][WORD_W-1:0] line_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0] tag_t;
  // tag and index joined, i.e. the byte address without offset bits
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;

  // one tag array entry
  typedef struct packed {
    tag_t tag;
    logic valid;
    logic dirty;
  } tag_entry_t;

  // client word request
  typedef struct packed {
    addr_t addr;
    logic write;
    word_t wdata;
  } cache_req_t;

  // line request towards the backing store
  typedef struct packed {
    line_addr_t line_addr;
    logic write;
    line_t wline;
  } mem_req_t;

  typedef enum logic [1:0] {
    st_idle,
    st_compare,
    st_write_back,
    st_allocate
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/cache_tag_array.sv ====
`include "cache_config.svh"

`default_nettype none

module cache_tag_array (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_pkg::index_t      index,
  input  cache_pkg::tag_t        lookup_tag,
  input  logic                   we,
  input  cache_pkg::tag_entry_t  wentry,
  output logic                   hit,
  output cache_pkg::tag_entry_t  entry
);

  // one entry per set
  cache_pkg::tag_entry_t entries [`CACHE_NUM_SETS];

  // combinational lookup
  assign entry = entries[index];

  // match only counts on a valid line
  assign hit = entry.valid && (entry.tag == lookup_tag);

  always_ff @(posedge clk) begin
    if (reset) begin
      // all lines start invalid and clean
      for (int i = 0; i < `CACHE_NUM_SETS; i++) begin
        entries[i].valid <= 1'b0;
        entries[i].dirty <= 1'b0;
      end
    end else if (we) begin
      entries[index] <= wentry;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
`default_nettype none

module cache_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  input  cache_pkg::cache_req_t  req,
  output logic                   ready,
  output logic                   resp_valid,
  output cache_pkg::word_t       rdata,
  output logic                   hit
);

  // controller to arrays
  cache_pkg::index_t index;
  cache_pkg::offset_t offset;
  logic tag_hit;
  cache_pkg::tag_entry_t victim;
  cache_pkg::line_t line;
  cache_pkg::word_t word;
  logic tag_we;
  cache_pkg::tag_entry_t tag_wentry;
  logic data_we;
  cache_pkg::line_t data_wline;
  cache_pkg::word_t data_wword;
  logic data_merge;

  // controller to memory
  logic mem_valid;
  cache_pkg::mem_req_t mem_req;
  logic mem_ready;
  logic mem_done;
  cache_pkg::line_t mem_rline;

  cache_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req        (req),
    .ready      (ready),
    .resp_valid (resp_valid),
    .rdata      (rdata),
    .hit        (hit),
    .index      (index),
    .offset     (offset),
    .tag_hit    (tag_hit),
    .victim     (victim),
    .line       (line),
    .word       (word),
    .tag_we     (tag_we),
    .tag_wentry (tag_wentry),
    .data_we    (data_we),
    .data_wline (data_wline),
    .data_wword (data_wword),
    .data_merge (data_merge),
    .mem_valid  (mem_valid),
    .mem_req    (mem_req),
    .mem_ready  (mem_ready),
    .mem_done   (mem_done),
    .mem_rline  (mem_rline)
  );

  // the controller keeps the latched request tag on tag_wentry
  // in every state, so it doubles as the lookup tag
  cache_tag_array u_tags (
    .clk        (clk),
    .reset      (reset),
    .index      (index),
    .lookup_tag (tag_wentry.tag),
    .we         (tag_we),
    .wentry     (tag_wentry),
    .hit        (tag_hit),
    .entry      (victim)
  );

  cache_data_array u_data (
    .clk    (clk),
    .index  (index),
    .offset (offset),
    .we     (data_we),
    .merge  (data_merge),
    .wline  (data_wline),
    .wword  (data_wword),
    .line   (line),
    .word   (word)
  );

  line_memory u_mem (
    .clk   (clk),
    .reset (reset),
    .valid (mem_valid),
    .req   (mem_req),
    .ready (mem_ready),
    .done  (mem_done),
    .rline (mem_rline)
  );

endmodule

`default_nettype wire

// ==== verilog/line_memory.sv ====
`include "cache_config.svh"

`default_nettype none

module line_memory (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 valid,
  input  cache_pkg::mem_req_t  req,
  output logic                 ready,
  output logic                 done,
  output cache_pkg::line_t     rline
);

  localparam int MEM_AW = $clog2(`CACHE_MEM_LINES);
  localparam int CNT_W = $clog2(`CACHE_MEM_LATENCY + 1);

  cache_pkg::line_t mem [`CACHE_MEM_LINES];
  cache_pkg::mem_req_t req_q;
  logic busy;
  logic [CNT_W-1:0] count;
  logic [MEM_AW-1:0] row;
  logic finish;

  // upper line address bits are not decoded
  assign row = req_q.line_addr[MEM_AW-1:0];
  assign ready = !busy;
  // last busy cycle, the access happens on this edge
  assign finish = busy && (count == CNT_W'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      count <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        if (valid) begin
          busy <= 1'b1;
          count <= CNT_W'(`CACHE_MEM_LATENCY);
        end
      end else if (finish) begin
        busy <= 1'b0;
        done <= 1'b1;
      end else begin
        count <= count - CNT_W'(1);
      end
    end
  end

  // request captured on acceptance
  always_ff @(posedge clk) begin
    if (valid && !busy) begin
      req_q <= req;
    end
  end

  // storage starts all zero
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CACHE_MEM_LINES; i++) begin
        mem[i] <= '0;
      end
    end else if (finish && req_q.write) begin
      mem[row] <= req_q.wline;
    end
  end

  // read data lines up with done
  always_ff @(posedge clk) begin
    if (finish && !req_q.write) begin
      rline <= mem[row];
    end
  end

endmodule

`default_nettype wire
